// File: source/prefetch_cfg.svh
// Build-time sizes for the prefetch buffer
// FIFO depth must stay at 3 or more, one slot is kept for the request in flight
`ifndef PREFETCH_CFG_SVH
`define PREFETCH_CFG_SVH

////////////////////////////////////////////////////////////
// Widths
////////////////////////////////////////////////////////////

// Byte address into instruction memory
`define PF_ADDR_W 32

// One memory word, holds two halfwords
`define PF_WORD_W 32

// Word entries in the fetch FIFO
`define PF_FIFO_DEPTH 4

`endif

// File: source/prefetch_pkg.sv
// Shared types of the prefetch buffer
// Widths come from the cfg header
`default_nettype none

`include "prefetch_cfg.svh"

package prefetch_pkg;

  ////////////////////////////////////////////////////////////
  // Data types
  ////////////////////////////////////////////////////////////

  // Byte address, bit 1 selects the halfword
  typedef logic [`PF_ADDR_W-1:0] addr_t;

  // Raw memory word
  typedef logic [`PF_WORD_W-1:0] word_t;

  // Memory-side fetch FSM
  typedef enum logic [1:0] {FETCH_IDLE, FETCH_WAIT_GNT, FETCH_WAIT_RVALID,
                            FETCH_WAIT_ABORTED} fetch_state_e;

endpackage

`default_nettype wire

// File: source/fetch_ctrl.sv
// Memory request FSM, at most one request outstanding
// A branch without req_i high is not remembered
`timescale 1ns/100ps
`default_nettype none

`include "prefetch_cfg.svh"

module fetch_ctrl import prefetch_pkg::*; (
  input  wire   clk,
  input  wire   rst_n,
  // Core control
  input  logic  req_i,
  input  logic  branch_i,
  input  addr_t branch_addr_i,
  // FIFO has space for one more word
  input  logic  room_i,
  // Instruction memory
  output logic  instr_req_o,
  output addr_t instr_addr_o,
  input  logic  instr_gnt_i,
  input  logic  instr_rvalid_i,
  // Toward FIFO and aligner
  output logic  push_o,
  output addr_t push_addr_o,
  output logic  busy_o
);

  fetch_state_e state_q, state_d;

  // Address of the last issued request, keeps bit 1 of a branch target
  addr_t addr_q;
  addr_t next_addr;
  addr_t req_addr;
  logic  addr_load;

  ////////////////////////////////////////////////////////////
  // Sequential address
  ////////////////////////////////////////////////////////////

  // Word after the last request
  assign next_addr = {addr_q[`PF_ADDR_W-1:2], 2'b00} + `PF_ADDR_W'(4);

  // Memory only sees word addresses
  assign instr_addr_o = {req_addr[`PF_ADDR_W-1:2], 2'b00};

  // Returning word belongs to the stored request
  assign push_addr_o = addr_q;

  assign busy_o = (state_q != FETCH_IDLE) || instr_req_o;

  ////////////////////////////////////////////////////////////
  // Next state and request outputs
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    instr_req_o = 1'b0;
    req_addr    = next_addr;
    push_o      = 1'b0;
    addr_load   = 1'b0;

    case (state_q)
      // Nothing outstanding
      FETCH_IDLE: begin
        if (branch_i) begin
          req_addr = branch_addr_i;
        end
        // Branch may always issue, sequential only with room
        if (req_i && (room_i || branch_i)) begin
          instr_req_o = 1'b1;
          addr_load   = 1'b1;
          state_d     = instr_gnt_i ? FETCH_WAIT_RVALID : FETCH_WAIT_GNT;
        end
      end

      // Request up, no grant yet
      FETCH_WAIT_GNT: begin
        instr_req_o = 1'b1;
        req_addr    = addr_q;
        // Not granted, so the target can still be swapped
        if (branch_i) begin
          req_addr  = branch_addr_i;
          addr_load = 1'b1;
        end
        state_d = instr_gnt_i ? FETCH_WAIT_RVALID : FETCH_WAIT_GNT;
      end

      // Granted, data still on its way
      FETCH_WAIT_RVALID: begin
        if (branch_i) begin
          req_addr = branch_addr_i;
        end
        if (req_i && (room_i || branch_i)) begin
          if (instr_rvalid_i) begin
            // Back-to-back: store word and issue the next one
            instr_req_o = 1'b1;
            push_o      = 1'b1;
            addr_load   = 1'b1;
            state_d     = instr_gnt_i ? FETCH_WAIT_RVALID : FETCH_WAIT_GNT;
          end else if (branch_i) begin
            // Old data must still drain, park the target
            addr_load = 1'b1;
            state_d   = FETCH_WAIT_ABORTED;
          end
        end else if (instr_rvalid_i) begin
          // No new request wanted or no room
          push_o  = 1'b1;
          state_d = FETCH_IDLE;
        end
      end

      // Dropping the rvalid of an aborted request
      FETCH_WAIT_ABORTED: begin
        req_addr = addr_q;
        if (branch_i) begin
          req_addr  = branch_addr_i;
          addr_load = 1'b1;
        end
        // Aborted word is thrown away, target goes out now
        if (instr_rvalid_i) begin
          instr_req_o = 1'b1;
          state_d     = instr_gnt_i ? FETCH_WAIT_RVALID : FETCH_WAIT_GNT;
        end
      end

      default: begin
        state_d = FETCH_IDLE;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= FETCH_IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      if (addr_load) begin
        addr_q <= req_addr;
      end
    end
  end

  // Pending request keeps its address unless a new branch replaces it
  a_req_addr_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (instr_req_o && !instr_gnt_i) ##1 !branch_i |-> instr_req_o && $stable(instr_addr_o)
  );

endmodule

`default_nettype wire

// File: source/fetch_fifo.sv
// Word FIFO with bypass of the incoming word on both output ports
// Clear empties it at the next edge, a push in the same cycle is lost
`timescale 1ns/100ps
`default_nettype none

`include "prefetch_cfg.svh"

module fetch_fifo import prefetch_pkg::*; (
  input  wire   clk,
  input  wire   rst_n,
  input  logic  clear_i,
  input  logic  push_i,
  input  word_t push_data_i,
  output logic  room_o,
  input  logic  pop_i,
  output word_t head_o,
  output word_t next_o,
  output logic  head_valid_o,
  output logic  next_valid_o
);

  localparam int DEPTH = `PF_FIFO_DEPTH;

  // Entry 0 is the head
  word_t             data_q [DEPTH];
  word_t             data_d [DEPTH];
  logic  [DEPTH-1:0] valid_q;
  logic  [DEPTH-1:0] valid_d;
  logic              placed;

  ////////////////////////////////////////////////////////////
  // Output ports
  ////////////////////////////////////////////////////////////

  // Empty FIFO shows the word arriving now
  assign head_o       = valid_q[0] ? data_q[0] : push_data_i;
  assign head_valid_o = valid_q[0] || push_i;

  // Second word, bypassed when only the head is stored
  assign next_o       = valid_q[1] ? data_q[1] : push_data_i;
  assign next_valid_o = valid_q[1] || (valid_q[0] && push_i);

  // Keep one slot free for the word in flight
  assign room_o = !valid_q[DEPTH-2];

  ////////////////////////////////////////////////////////////
  // Push then pop
  ////////////////////////////////////////////////////////////

  always_comb begin
    data_d  = data_q;
    valid_d = valid_q;
    placed  = 1'b0;

    // First free slot takes the new word
    if (push_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        if (!valid_q[i] && !placed) begin
          data_d[i]  = push_data_i;
          valid_d[i] = 1'b1;
          placed     = 1'b1;
        end
      end
    end

    // Shift everything down one word
    if (pop_i) begin
      for (int i = 0; i < DEPTH-1; i++) begin
        data_d[i]  = data_d[i+1];
        valid_d[i] = valid_d[i+1];
      end
      valid_d[DEPTH-1] = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (clear_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  // Word storage
  always_ff @(posedge clk) begin
    data_q <= data_d;
  end

  // Overflow only if the controller ignored room_o
  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    push_i |-> (!valid_q[DEPTH-1] || clear_i)
  );

endmodule

`default_nettype wire

// File: source/instr_aligner.sv
// Cuts 16-bit and 32-bit instructions out of the FIFO word stream
// PC is taken from the first word pushed after a clear
`timescale 1ns/100ps
`default_nettype none

`include "prefetch_cfg.svh"

module instr_aligner import prefetch_pkg::*; (
  input  wire   clk,
  input  wire   rst_n,
  input  logic  clear_i,
  input  logic  push_i,
  input  addr_t push_addr_i,
  // FIFO heads
  input  word_t head_i,
  input  word_t next_i,
  input  logic  head_valid_i,
  input  logic  next_valid_i,
  output logic  pop_o,
  // Core port
  output logic  valid_o,
  input  logic  ready_i,
  output word_t rdata_o,
  output addr_t addr_o
);

  addr_t pc_q;
  logic  pc_valid_q;
  addr_t pc;
  addr_t pc_next;
  logic  is_compressed;
  logic  take;

  ////////////////////////////////////////////////////////////
  // Current instruction
  ////////////////////////////////////////////////////////////

  // Before the first word lands the PC comes from the push
  assign pc       = pc_valid_q ? pc_q : push_addr_i;
  assign addr_o   = pc;

  // Upper half of head joined with lower half of next
  assign rdata_o = pc[1] ? {next_i[15:0], head_i[31:16]} : head_i;

  // RVC: low two bits not both one
  assign is_compressed = (rdata_o[1:0] != 2'b11);

  // Next word only needed when a 32-bit instruction straddles
  // FIFO and PC flag clear together, so a head word implies a known PC
  always_comb begin
    valid_o = head_valid_i;
    if (pc[1] && !is_compressed) begin
      valid_o = valid_o && next_valid_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // PC update
  ////////////////////////////////////////////////////////////

  // Branch in the same cycle cancels the handshake
  assign take = valid_o && ready_i && !clear_i;

  assign pc_next = pc + (is_compressed ? `PF_ADDR_W'(2) : `PF_ADDR_W'(4));

  // Leaving the head word when ending at or past its upper half
  assign pop_o = take && (pc[1] || !is_compressed);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q       <= '0;
      pc_valid_q <= 1'b0;
    end else if (clear_i) begin
      pc_valid_q <= 1'b0;
    end else if (take) begin
      pc_q       <= pc_next;
      pc_valid_q <= 1'b1;
    end else if (push_i && !pc_valid_q) begin
      // Latch the branch target even if not taken yet
      pc_q       <= push_addr_i;
      pc_valid_q <= 1'b1;
    end
  end

  // Stalled output holds across the bypass-to-stored handover
  a_hold_on_stall: assert property (
    @(posedge clk) disable iff (!rst_n)
    (valid_o && !ready_i && !clear_i) |=>
      valid_o && $stable(addr_o) && $stable(rdata_o[15:0]) &&
      (is_compressed || $stable(rdata_o[31:16]))
  );

endmodule

`default_nettype wire

// File: source/prefetch_buffer.sv
// Instruction prefetch buffer, req/gnt/rvalid memory side, valid/ready core side
// branch_i must be a single-cycle pulse with req_i high
`timescale 1ns/100ps
`default_nettype none

`include "prefetch_cfg.svh"

module prefetch_buffer import prefetch_pkg::*; (
  input  wire   clk,
  input  wire   rst_n,
  // Core control
  input  logic  req_i,
  input  logic  branch_i,
  input  addr_t addr_i,
  // Instruction out
  input  logic  ready_i,
  output logic  valid_o,
  output word_t rdata_o,
  output addr_t addr_o,
  // Instruction memory
  output logic  instr_req_o,
  input  logic  instr_gnt_i,
  output addr_t instr_addr_o,
  input  word_t instr_rdata_i,
  input  logic  instr_rvalid_i,
  // Status
  output logic  busy_o
);

  logic  fifo_room;
  logic  fifo_push;
  addr_t push_addr;
  word_t fifo_head;
  word_t fifo_next;
  logic  fifo_head_valid;
  logic  fifo_next_valid;
  logic  fifo_pop;

  ////////////////////////////////////////////////////////////
  // Controller, FIFO, aligner chain
  ////////////////////////////////////////////////////////////

  fetch_ctrl u_fetch_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .branch_addr_i  (addr_i),
    .room_i         (fifo_room),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .push_o         (fifo_push),
    .push_addr_o    (push_addr),
    .busy_o         (busy_o)
  );

  // Read data goes straight into storage
  fetch_fifo u_fetch_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .clear_i      (branch_i),
    .push_i       (fifo_push),
    .push_data_i  (instr_rdata_i),
    .room_o       (fifo_room),
    .pop_i        (fifo_pop),
    .head_o       (fifo_head),
    .next_o       (fifo_next),
    .head_valid_o (fifo_head_valid),
    .next_valid_o (fifo_next_valid)
  );

  instr_aligner u_instr_aligner (
    .clk          (clk),
    .rst_n        (rst_n),
    .clear_i      (branch_i),
    .push_i       (fifo_push),
    .push_addr_i  (push_addr),
    .head_i       (fifo_head),
    .next_i       (fifo_next),
    .head_valid_i (fifo_head_valid),
    .next_valid_i (fifo_next_valid),
    .pop_o        (fifo_pop),
    .valid_o      (valid_o),
    .ready_i      (ready_i),
    .rdata_o      (rdata_o),
    .addr_o       (addr_o)
  );

endmodule

`default_nettype wire

// File: sim/instr_mem_model.sv
// Instruction memory responder with random grant and rvalid delays
// Content table holds 256 words and wraps, one granted request is tracked at a time
`timescale 1ns/100ps
`default_nettype none

module instr_mem_model import prefetch_pkg::*; (
  input  wire   clk,
  input  logic  req_i,
  input  addr_t addr_i,
  output logic  gnt_o,
  output logic  rvalid_o,
  output word_t rdata_o
);

  localparam int TABLE_WORDS = 256;

  // Content shared with the shadow model in the testbench
  word_t  mem_words [TABLE_WORDS];
  integer seed;
  int     gnt_wait;
  int     rvalid_wait;
  logic   pending;
  addr_t  pending_addr;

  // Extra cycles of delay, 0 to 2
  function automatic int draw_delay();
    return int'($unsigned($random(seed)) % 3);
  endfunction

  ////////////////////////////////////////////////////////////
  // Content fill and responder
  ////////////////////////////////////////////////////////////

  initial begin
    seed = 32'hd03d2654;
    // Random low bits mix 16-bit and 32-bit encodings
    for (int i = 0; i < TABLE_WORDS; i++) begin
      mem_words[i] = $random(seed);
    end
    gnt_o        = 1'b0;
    rvalid_o     = 1'b0;
    rdata_o      = '0;
    pending      = 1'b0;
    pending_addr = '0;
    gnt_wait     = -1;
    rvalid_wait  = 0;
    forever begin
      @(negedge clk);
      gnt_o    = 1'b0;
      rvalid_o = 1'b0;
      // Data phase of the granted request
      if (pending) begin
        if (rvalid_wait == 0) begin
          rvalid_o = 1'b1;
          rdata_o  = mem_words[pending_addr[9:2]];
          pending  = 1'b0;
        end else begin
          rvalid_wait = rvalid_wait - 1;
        end
      end
      // Request may depend on rvalid, let it settle
      #1;
      if (!req_i) begin
        gnt_wait = -1;
      end else begin
        if (gnt_wait < 0) begin
          gnt_wait = draw_delay();
        end
        if (gnt_wait == 0) begin
          gnt_o        = 1'b1;
          pending      = 1'b1;
          pending_addr = addr_i;
          rvalid_wait  = draw_delay();
          gnt_wait     = -1;
        end else begin
          gnt_wait = gnt_wait - 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/prefetch_buffer_tb.sv
// Self-checking testbench, memory content and delays follow one fixed seed
// Branch targets stay inside the 256-word content table
`timescale 1ns/100ps
`default_nettype none

module prefetch_buffer_tb import prefetch_pkg::*; ();

  localparam int  NUM_PHASES   = 4;
  localparam int  PHASE_CYCLES = 2000;
  localparam time CLK_PERIOD   = 100;

  logic  clk;
  logic  rst_n;
  logic  req_i, branch_i, ready_i;
  addr_t addr_i;
  logic  valid_o, busy_o;
  word_t rdata_o;
  addr_t addr_o;
  logic  instr_req_o, instr_gnt_i, instr_rvalid_i;
  addr_t instr_addr_o;
  word_t instr_rdata_i;

  integer seed;
  logic   started;

  // Shadow of the instruction stream
  addr_t       exp_pc;
  logic [15:0] exp_lo, exp_hi;
  logic        exp_rvc;
  logic        take;
  int          taken;

  // Seen at the last edge
  logic  stall_q, stall_rvc, wait_gnt_q, outstanding_q;
  addr_t stall_addr, wait_addr;
  word_t stall_data;

  prefetch_buffer dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .addr_i         (addr_i),
    .ready_i        (ready_i),
    .valid_o        (valid_o),
    .rdata_o        (rdata_o),
    .addr_o         (addr_o),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rdata_i  (instr_rdata_i),
    .instr_rvalid_i (instr_rvalid_i),
    .busy_o         (busy_o)
  );

  instr_mem_model u_mem (
    .clk      (clk),
    .req_i    (instr_req_o),
    .addr_i   (instr_addr_o),
    .gnt_o    (instr_gnt_i),
    .rvalid_o (instr_rvalid_i),
    .rdata_o  (instr_rdata_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    abort_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // Halfword of the content table at a byte address
  function automatic logic [15:0] table_half(input addr_t a);
    word_t w;
    w = u_mem.mem_words[a[9:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  function automatic int rand_pct();
    return int'($unsigned($random(seed)) % 100);
  endfunction

  // Aligned or halfword target inside the table
  function automatic addr_t random_target();
    return addr_t'($unsigned($random(seed)) & 32'h0000_03fe);
  endfunction

  ////////////////////////////////////////////////////////////
  // Shadow model and trackers
  ////////////////////////////////////////////////////////////

  assign exp_lo  = table_half(exp_pc);
  assign exp_hi  = table_half(exp_pc + 32'd2);
  assign exp_rvc = (exp_lo[1:0] != 2'b11);
  // Branch cancels the handshake
  assign take    = valid_o && ready_i && !branch_i;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_pc        <= '0;
      taken         <= 0;
      stall_q       <= 1'b0;
      wait_gnt_q    <= 1'b0;
      outstanding_q <= 1'b0;
    end else begin
      if (branch_i) begin
        exp_pc <= addr_i;
      end else if (take) begin
        exp_pc <= exp_pc + (exp_rvc ? 32'd2 : 32'd4);
        taken  <= taken + 1;
      end
      stall_q    <= valid_o && !ready_i && !branch_i;
      stall_addr <= addr_o;
      stall_data <= rdata_o;
      stall_rvc  <= exp_rvc;
      wait_gnt_q <= instr_req_o && !instr_gnt_i;
      wait_addr  <= instr_addr_o;
      // Granted until its rvalid, a new grant may share that cycle
      if (instr_req_o && instr_gnt_i) begin
        outstanding_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        outstanding_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
    !started |-> !instr_req_o && !valid_o && !busy_o)
    else abort_run("DUT became active before req_i was raised");

  a_take_addr: assert property (@(posedge clk) disable iff (!rst_n)
    take |-> addr_o == exp_pc)
    else report_mismatch("addr_o", $sampled(addr_o), $sampled(exp_pc));

  a_take_lo: assert property (@(posedge clk) disable iff (!rst_n)
    take |-> rdata_o[15:0] == exp_lo)
    else report_mismatch("rdata_o[15:0]", {16'h0, $sampled(rdata_o[15:0])},
                         {16'h0, $sampled(exp_lo)});

  // Upper half only for 32-bit instructions, including the spanning ones
  a_take_hi: assert property (@(posedge clk) disable iff (!rst_n)
    take && !exp_rvc |-> rdata_o[31:16] == exp_hi)
    else report_mismatch("rdata_o[31:16]", {16'h0, $sampled(rdata_o[31:16])},
                         {16'h0, $sampled(exp_hi)});

  a_stall_valid: assert property (@(posedge clk) disable iff (!rst_n)
    stall_q |-> valid_o)
    else abort_run("valid_o dropped while the core was stalling");

  a_stall_addr: assert property (@(posedge clk) disable iff (!rst_n)
    stall_q |-> addr_o == stall_addr)
    else report_mismatch("addr_o", $sampled(addr_o), $sampled(stall_addr));

  a_stall_data: assert property (@(posedge clk) disable iff (!rst_n)
    stall_q |-> rdata_o[15:0] == stall_data[15:0] &&
                (stall_rvc || rdata_o[31:16] == stall_data[31:16]))
    else report_mismatch("rdata_o", $sampled(rdata_o), $sampled(stall_data));

  // A branch may swap the target of an ungranted request
  a_gnt_wait_req: assert property (@(posedge clk) disable iff (!rst_n)
    wait_gnt_q && !branch_i |-> instr_req_o)
    else abort_run("instr_req_o dropped before its grant");

  a_gnt_wait_addr: assert property (@(posedge clk) disable iff (!rst_n)
    wait_gnt_q && !branch_i |-> instr_addr_o == wait_addr)
    else report_mismatch("instr_addr_o", $sampled(instr_addr_o), $sampled(wait_addr));

  a_single_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding_q && instr_req_o |-> instr_rvalid_i)
    else abort_run("second request raised before the rvalid of the first");

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Until n more instructions are taken, with random stalls and branch pulses
  task automatic run_instrs(input int n, input int stall_pct, input int branch_pct);
    int goal;
    goal = taken + n;
    while (taken < goal) begin
      @(negedge clk);
      ready_i = rand_pct() >= stall_pct;
      if (!branch_i && rand_pct() < branch_pct) begin
        branch_i = 1'b1;
        addr_i   = random_target();
      end else begin
        branch_i = 1'b0;
      end
    end
  endtask

  // Branch once a granted request still waits for its data
  task automatic branch_while_outstanding(input addr_t target);
    @(negedge clk);
    while (!outstanding_q) begin
      @(negedge clk);
    end
    branch_i = 1'b1;
    addr_i   = target;
  endtask

  initial begin
    seed     = 32'hd03d2654;
    rst_n    = 1'b0;
    req_i    = 1'b0;
    branch_i = 1'b0;
    addr_i   = '0;
    ready_i  = 1'b0;
    started  = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Quiet window after reset
    repeat (4) @(negedge clk);

    // Straight-line flow from an aligned target
    req_i    = 1'b1;
    started  = 1'b1;
    ready_i  = 1'b1;
    branch_i = 1'b1;
    addr_i   = 32'h0000_0040;
    run_instrs(200, 0, 0);

    // Redirects, many of them abort a request in flight
    for (int i = 0; i < 24; i++) begin
      branch_while_outstanding(random_target());
      run_instrs(3, 0, 0);
    end

    // Back-pressure mixed with branches
    run_instrs(300, 40, 5);

    @(negedge clk);
    branch_i = 1'b0;
    ready_i  = 1'b1;
    repeat (4) @(negedge clk);
    $display("All tests passed!");
    $finish;
  end

  // Budget of cycles per phase
  initial begin
    repeat (NUM_PHASES * PHASE_CYCLES) @(posedge clk);
    abort_run("Watchdog expired before all phases finished");
  end

endmodule

`default_nettype wire

// File: prefetch_buffer.f
+incdir+source
source/prefetch_pkg.sv
source/fetch_ctrl.sv
source/fetch_fifo.sv
source/instr_aligner.sv
source/prefetch_buffer.sv
sim/instr_mem_model.sv
sim/prefetch_buffer_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the prefetch buffer testbench with Verilator and run it
# Exit status is nonzero when the build or any check fails
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module prefetch_buffer_tb -f prefetch_buffer.f -o prefetch_buffer_tb \
  && ./obj_dir/prefetch_buffer_tb \
  || { echo "simulation run failed"; exit 1; }
